//--- Bender.yml
package:
  name: fm_mmr

sources:
  - include_dirs:
      - .
    files:
      - fm_pkg.sv
      - fm_mmr_ctrl.sv
      - fm_clk_div.sv
      - fm_timers.sv
      - fm_op_regs.sv
      - fm_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fm_assertions.sv
      - fm_tb.sv

//--- flist.f
+incdir+.
fm_pkg.sv
fm_mmr_ctrl.sv
fm_clk_div.sv
fm_timers.sv
fm_op_regs.sv
fm_top.sv
fm_assertions.sv
fm_tb.sv

//--- fm_assertions.sv
`default_nettype none

`include "fm_defines.svh"

module fm_assertions (
	input logic             clk,
	input logic             rst,
	input logic             clk_en,
	input logic             busy,
	input logic             irq,
	input logic             flag_a,
	input logic             flag_b,
	input fm_pkg::fm_slot_t slot
);
	import fm_pkg::*;

	int fail_count = 0; // failed assertion count, read from the testbench

	// synthesis tick is one clk wide
	tick_single: assert property (@(posedge clk) disable iff (rst) clk_en |=> !clk_en)
		else begin
			$error("clk_en high on two consecutive cycles");
			fail_count++;
		end

	// flags are unknown until the first reset edge
	irq_is_or: assert property (@(posedge clk) disable iff (rst)
		irq == (flag_a | flag_b))
		else begin
			$error("irq differs from flag_a | flag_b");
			fail_count++;
		end

	// sequencer never leaves 0..23
	slot_range: assert property (@(posedge clk) disable iff (rst)
		slot < fm_slot_t'(`FM_NUM_SLOTS))
		else begin
			$error("slot out of range");
			fail_count++;
		end

	busy_after_rst: assert property (@(posedge clk) rst |=> !busy)
		else begin
			$error("busy high in the cycle after reset");
			fail_count++;
		end

endmodule

bind fm_top fm_assertions u_fm_assertions (
	.clk    (clk),
	.rst    (rst),
	.clk_en (clk_en),
	.busy   (busy),
	.irq    (irq),
	.flag_a (flag_a),
	.flag_b (flag_b),
	.slot   (slot)
);

`default_nettype wire

//--- fm_clk_div.sv
`default_nettype none

module fm_clk_div (
	input  logic            clk,
	input  logic            rst,
	input  logic            div_wr,  // new divide value
	input  fm_pkg::fm_div_t div_sel,
	output logic            clk_en   // one synthesis tick
);
	import fm_pkg::*;

	fm_div_t cnt;  // prescale count
	fm_div_t term; // terminal count in use
	fm_div_t pend; // requested terminal count

	// tick on the last count of each interval
	assign clk_en = (cnt == term);

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt  <= '0;
			term <= 3'd5; // divide by 6
			pend <= 3'd5;
		end else begin
			if (div_wr)
				pend <= div_sel;
			if (cnt == term) begin
				cnt <= '0;
				// new value only at the wrap, no short interval
				term <= div_wr ? div_sel : pend;
			end else begin
				cnt <= cnt + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- fm_defines.svh
`ifndef FM_DEFINES_SVH
`define FM_DEFINES_SVH

// operator slots, 6 channels x 4 operators
`define FM_NUM_SLOTS      24
`define FM_BUSY_TICKS     32 // synthesis ticks per data write
`define FM_TMRB_PRESCALE  16 // clk_en pulses per timer B tick

// global register map
`define FM_REG_LFO        8'h22
`define FM_REG_CLKA1      8'h24 // timer A preset bits 9..2
`define FM_REG_CLKA2      8'h25 // timer A preset bits 1..0
`define FM_REG_CLKB       8'h26
`define FM_REG_TIMER      8'h27 // load, irq enable, flag clear
`define FM_REG_CLK_N6     8'h2D
`define FM_REG_CLK_N3     8'h2E
`define FM_REG_CLK_N2     8'h2F

// operator register groups, upper nibble of the address
`define FM_GRP_DT_MUL     4'h3
`define FM_GRP_TL         4'h4
`define FM_GRP_KS_AR      4'h5

`endif

//--- fm_mmr_ctrl.sv
`default_nettype none

`include "fm_defines.svh"

module fm_mmr_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr,       // host strobe
	input  logic [1:0]        addr,     // bit 0 data, bit 1 bank
	input  fm_pkg::fm_reg_t   din,
	input  logic              clk_en,
	output logic              busy,
	output logic              lfo_en,
	output logic [2:0]        lfo_freq,
	output logic              div_wr,
	output fm_pkg::fm_div_t   div_sel,
	output fm_pkg::fm_tmra_t  preset_a,
	output fm_pkg::fm_tmrb_t  preset_b,
	output logic              load_a,
	output logic              load_b,
	output logic              irq_en_a,
	output logic              irq_en_b,
	output logic              clr_a,
	output logic              clr_b,
	output logic              op_wr,
	output fm_pkg::fm_slot_t  op_slot,
	output logic [1:0]        op_field, // 0 dt/mul, 1 tl, 2 ks/ar
	output fm_pkg::fm_reg_t   op_data
);
	import fm_pkg::*;

	fm_reg_t        sel_reg;    // latched by address writes
	fm_reg_t        reg_q;      // target of the pending data write
	fm_reg_t        data_q;
	logic           bank_q;     // channels 4..6
	logic           data_wr_q;  // data write waiting for decode
	fm_slot_t       wr_slot;
	logic [1:0]     wr_field;
	logic           wr_is_op;
	fm_busy_state_e busy_state;
	logic [4:0]     busy_cnt;

	// host port, first stage
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg   <= '0;
			data_wr_q <= 1'b0;
		end else begin
			data_wr_q <= wr & addr[0];
			if (wr & ~addr[0])
				sel_reg <= din; // address write
		end
	end

	// snapshot of the data write
	always_ff @(posedge clk) begin
		if (wr & addr[0]) begin
			reg_q  <= sel_reg;
			data_q <= din;
			bank_q <= addr[1];
		end
	end

	// operator group and field
	always_comb begin
		wr_is_op = (reg_q[1:0] != 2'b11); // low field 3 is a hole
		case (reg_q[7:4])
			`FM_GRP_DT_MUL: wr_field = 2'd0;
			`FM_GRP_TL:     wr_field = 2'd1;
			`FM_GRP_KS_AR:  wr_field = 2'd2;
			default: begin
				wr_field = 2'd0;
				wr_is_op = 1'b0; // not an operator register
			end
		endcase
	end

	// slot = 6*op + 3*bank + channel
	assign wr_slot = 5'(reg_q[3:2]) * 5'd6 + (bank_q ? 5'd3 : 5'd0) + 5'(reg_q[1:0]);

	// global register map, second stage
	always_ff @(posedge clk) begin
		if (rst) begin
			lfo_en   <= 1'b0;
			lfo_freq <= 3'd0;
			div_wr   <= 1'b0;
			div_sel  <= 3'd5; // divide by 6
			preset_a <= '0;
			preset_b <= '0;
			load_a   <= 1'b0;
			load_b   <= 1'b0;
			irq_en_a <= 1'b0;
			irq_en_b <= 1'b0;
			clr_a    <= 1'b0;
			clr_b    <= 1'b0;
			op_wr    <= 1'b0;
		end else begin
			div_wr <= 1'b0; // strobes last one cycle
			clr_a  <= 1'b0;
			clr_b  <= 1'b0;
			op_wr  <= data_wr_q & wr_is_op;
			if (data_wr_q) begin
				case (reg_q)
					`FM_REG_LFO:   {lfo_en, lfo_freq} <= data_q[3:0];
					`FM_REG_CLKA1: preset_a[9:2] <= data_q;
					`FM_REG_CLKA2: preset_a[1:0] <= data_q[1:0];
					`FM_REG_CLKB:  preset_b <= data_q;
					`FM_REG_TIMER: begin
						{clr_b, clr_a} <= data_q[5:4];
						{irq_en_b, irq_en_a} <= data_q[3:2];
						{load_b, load_a} <= data_q[1:0];
					end
					`FM_REG_CLK_N6: begin
						div_sel <= 3'd5;
						div_wr  <= 1'b1;
					end
					`FM_REG_CLK_N3: begin
						div_sel <= 3'd2;
						div_wr  <= 1'b1;
					end
					`FM_REG_CLK_N2: begin
						div_sel <= 3'd1;
						div_wr  <= 1'b1;
					end
					default: ; // operator groups handled below
				endcase
			end
		end
	end

	// operator write payload
	always_ff @(posedge clk) begin
		if (data_wr_q & wr_is_op) begin
			op_slot  <= wr_slot;
			op_field <= wr_field;
			op_data  <= data_q;
		end
	end

	// busy lasts FM_BUSY_TICKS synthesis ticks, restarted by each data write
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_state <= FM_IDLE;
			busy_cnt   <= '0;
		end else if (data_wr_q) begin
			busy_state <= FM_BUSY;
			busy_cnt   <= '0;
		end else begin
			case (busy_state)
				FM_BUSY: if (clk_en) begin
					if (busy_cnt == 5'(`FM_BUSY_TICKS - 1))
						busy_state <= FM_IDLE; // last tick
					busy_cnt <= busy_cnt + 5'd1;
				end
				default: busy_cnt <= '0;
			endcase
		end
	end

	assign busy = (busy_state == FM_BUSY);

endmodule

`default_nettype wire

//--- fm_op_regs.sv
`default_nettype none

`include "fm_defines.svh"

module fm_op_regs (
	input  logic             clk,
	input  logic             rst,
	input  logic             clk_en,
	input  logic             op_wr,
	input  fm_pkg::fm_slot_t op_slot,
	input  logic [1:0]       op_field, // 0 dt/mul, 1 tl, 2 ks/ar
	input  fm_pkg::fm_reg_t  op_data,
	output fm_pkg::fm_slot_t slot,     // slot being presented
	output logic [2:0]       dt1,
	output logic [3:0]       mul,
	output logic [6:0]       tl,
	output logic [1:0]       ks,
	output logic [4:0]       ar
);
	import fm_pkg::*;

	fm_reg_t  mem_dt_mul [`FM_NUM_SLOTS];
	fm_reg_t  mem_tl     [`FM_NUM_SLOTS];
	fm_reg_t  mem_ks_ar  [`FM_NUM_SLOTS];
	fm_slot_t slot_nxt;

	// sequencer step, 23 wraps to 0
	assign slot_nxt = (slot == 5'(`FM_NUM_SLOTS - 1)) ? '0 : slot + 5'd1;

	// host side, one byte per write
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_NUM_SLOTS; i++) begin
				mem_dt_mul[i] <= '0; // chip powers up silent
				mem_tl[i]     <= '0;
				mem_ks_ar[i]  <= '0;
			end
		end else if (op_wr) begin
			case (op_field)
				2'd0:    mem_dt_mul[op_slot] <= op_data;
				2'd1:    mem_tl[op_slot]     <= op_data;
				2'd2:    mem_ks_ar[op_slot]  <= op_data;
				default: ;
			endcase
		end
	end

	// pipeline side, next slot and its fields on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
			dt1  <= '0;
			mul  <= '0;
			tl   <= '0;
			ks   <= '0;
			ar   <= '0;
		end else if (clk_en) begin
			slot <= slot_nxt;
			dt1  <= mem_dt_mul[slot_nxt][6:4];
			mul  <= mem_dt_mul[slot_nxt][3:0];
			tl   <= mem_tl[slot_nxt][6:0];
			ks   <= mem_ks_ar[slot_nxt][7:6];
			ar   <= mem_ks_ar[slot_nxt][4:0]; // bit 5 unused
		end
	end

endmodule

`default_nettype wire

//--- fm_pkg.sv
`default_nettype none

package fm_pkg;

	// register address or data byte from the host
	typedef logic [7:0] fm_reg_t;

	// operator slot, 6*op + channel, 0..23
	typedef logic [4:0] fm_slot_t;

	// prescaler terminal count
	// 5, 2 or 1 for divide by 6, 3 or 2
	typedef logic [2:0] fm_div_t;

	typedef logic [9:0] fm_tmra_t; // timer A preset and count
	typedef logic [7:0] fm_tmrb_t; // timer B preset and count

	// busy flag sequencing
	typedef enum logic {
		FM_IDLE, // ready for the next write
		FM_BUSY  // counting synthesis ticks
	} fm_busy_state_e;

endpackage

`default_nettype wire

//--- fm_tb.sv
`default_nettype none

`include "fm_defines.svh"

module fm_tb;
	import fm_pkg::*;

	// one slot's fields as the pipeline sees them
	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
	} param_t;

	logic       clk;
	logic       rst;
	logic       wr;
	logic [1:0] addr;
	fm_reg_t    din;
	logic       busy;
	logic       clk_en;
	logic       irq;
	logic       flag_a;
	logic       flag_b;
	logic       lfo_en;
	logic [2:0] lfo_freq;
	fm_slot_t   slot;
	logic [2:0] dt1;
	logic [3:0] mul;
	logic [6:0] tl;
	logic [1:0] ks;
	logic [4:0] ar;

	// reference model
	fm_reg_t    sh_dt_mul [`FM_NUM_SLOTS];
	fm_reg_t    sh_tl     [`FM_NUM_SLOTS];
	fm_reg_t    sh_ks_ar  [`FM_NUM_SLOTS];
	int         ref_div;      // clk cycles per clk_en
	fm_tmra_t   ref_preset_a;
	fm_tmrb_t   ref_preset_b;
	logic [3:0] ref_lfo;      // {lfo_en, lfo_freq}
	bit         params_on;    // field compare enabled
	int         param_checks; // slots compared so far

	fm_top u_fm_top (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.din      (din),
		.busy     (busy),
		.clk_en   (clk_en),
		.irq      (irq),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.lfo_en   (lfo_en),
		.lfo_freq (lfo_freq),
		.slot     (slot),
		.dt1      (dt1),
		.mul      (mul),
		.tl       (tl),
		.ks       (ks),
		.ar       (ar)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_failed();
		$display("TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		stop_failed();
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at t=%0t while waiting for %s", $time, what);
		stop_failed();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_value_error(name, 32'(got), 32'(exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			report_value_error(name, got, exp);
	endtask

	task automatic check_slot_params(input fm_slot_t got_slot, input fm_slot_t exp_slot,
		input bit with_params, input param_t got, input param_t exp);
		if (got_slot !== exp_slot)
			report_value_error("slot", got_slot, exp_slot);
		if (with_params) begin
			if (got.dt1 !== exp.dt1)
				report_value_error($sformatf("dt1 slot %0d", exp_slot), got.dt1, exp.dt1);
			if (got.mul !== exp.mul)
				report_value_error($sformatf("mul slot %0d", exp_slot), got.mul, exp.mul);
			if (got.tl !== exp.tl)
				report_value_error($sformatf("tl slot %0d", exp_slot), got.tl, exp.tl);
			if (got.ks !== exp.ks)
				report_value_error($sformatf("ks slot %0d", exp_slot), got.ks, exp.ks);
			if (got.ar !== exp.ar)
				report_value_error($sformatf("ar slot %0d", exp_slot), got.ar, exp.ar);
		end
	endtask

	// field split of the three operator bytes
	function automatic param_t ref_param(input fm_slot_t s);
		param_t p;
		p.dt1 = sh_dt_mul[s][6:4];
		p.mul = sh_dt_mul[s][3:0];
		p.tl  = sh_tl[s][6:0];
		p.ks  = sh_ks_ar[s][7:6];
		p.ar  = sh_ks_ar[s][4:0]; // bit 5 unused
		return p;
	endfunction

	function automatic void update_model(input fm_reg_t r, input logic bank, input fm_reg_t d);
		int s;
		s = 6 * int'(r[3:2]) + 3 * int'(bank) + int'(r[1:0]); // 6*op + channel
		case (r)
			`FM_REG_LFO:    ref_lfo = d[3:0];
			`FM_REG_CLKA1:  ref_preset_a[9:2] = d;
			`FM_REG_CLKA2:  ref_preset_a[1:0] = d[1:0];
			`FM_REG_CLKB:   ref_preset_b = d;
			`FM_REG_CLK_N6: ref_div = 6;
			`FM_REG_CLK_N3: ref_div = 3;
			`FM_REG_CLK_N2: ref_div = 2;
			default: ;
		endcase
		if (r[1:0] != 2'd3) begin // low field 3 is a hole
			case (r[7:4])
				`FM_GRP_DT_MUL: sh_dt_mul[s] = d;
				`FM_GRP_TL:     sh_tl[s] = d;
				`FM_GRP_KS_AR:  sh_ks_ar[s] = d;
				default: ;
			endcase
		end
	endfunction

	task automatic write_addr(input fm_reg_t a, input logic bank);
		@(posedge clk);
		#1;
		wr   = 1'b1;
		addr = {bank, 1'b0};
		din  = a;
		@(posedge clk); // strobe taken here
		#1;
		wr = 1'b0;
	endtask

	task automatic write_data(input fm_reg_t d, input logic bank);
		@(posedge clk);
		#1;
		wr   = 1'b1;
		addr = {bank, 1'b1};
		din  = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
	endtask

	task automatic reg_write(input fm_reg_t r, input fm_reg_t d, input logic bank);
		write_addr(r, bank);
		write_data(d, bank);
		update_model(r, bank, d);
	endtask

	// past k register stages after a write, sampled mid cycle
	task automatic settle(input int k);
		repeat (k) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic wait_ticks(input int k);
		int seen;
		int i;
		seen = 0;
		for (i = 0; i < 8 * k + 16 && seen < k; i++) begin
			@(negedge clk);
			if (clk_en)
				seen++;
		end
		if (seen < k)
			report_timeout("clk_en pulses");
	endtask

	task automatic measure_interval(output int n);
		int i;
		i = 0;
		do begin
			@(negedge clk);
			i++;
		end while (!clk_en && i < 16);
		if (!clk_en)
			report_timeout("clk_en");
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!clk_en && n < 16);
		if (!clk_en)
			report_timeout("the following clk_en");
	endtask

	// counts clk_en pulses until busy falls (0), flag_a (1) or flag_b (2)
	task automatic count_ticks_until(input int skip, input int which, input int limit,
		output int n);
		int  i;
		bit  done;
		repeat (skip) @(negedge clk); // ticks that the write itself absorbs
		n    = 0;
		done = 1'b0;
		for (i = 0; i < limit && !done; i++) begin
			@(negedge clk);
			case (which)
				0:       done = !busy;
				1:       done = flag_a;
				default: done = flag_b;
			endcase
			if (!done && clk_en)
				n++;
		end
		if (!done)
			report_timeout(which == 0 ? "busy to fall" : "a timer flag");
	endtask

	task automatic wait_busy_low();
		int i;
		i = 0;
		do begin
			@(negedge clk);
			i++;
		end while (busy && i < 2000);
		if (busy)
			report_timeout("busy to fall");
	endtask

	task automatic wait_param_checks(input int k);
		int target;
		int i;
		target = param_checks + k;
		for (i = 0; i < 8 * k + 32 && param_checks < target; i++)
			@(negedge clk);
		if (param_checks < target)
			report_timeout("slot sweep");
	endtask

	// slot and fields after every clk_en
	initial begin : compare_on_tick
		fm_slot_t exp_slot;
		logic     tick_q;
		param_t   got_p;
		exp_slot = '0;
		tick_q   = 1'b0;
		forever begin
			@(negedge clk);
			if (rst) begin
				exp_slot = '0;
				tick_q   = 1'b0;
			end else begin
				if (tick_q) begin
					exp_slot = (exp_slot == fm_slot_t'(`FM_NUM_SLOTS - 1)) ? '0 : exp_slot + 5'd1;
					got_p    = {dt1, mul, tl, ks, ar};
					check_slot_params(slot, exp_slot, params_on, got_p, ref_param(exp_slot));
					if (params_on)
						param_checks++;
				end
				tick_q = clk_en;
			end
		end
	end

	initial begin : main_seq
		int         first_rnd;
		int         n;
		int         i;
		logic [3:0] grp;
		logic [1:0] op;
		logic [1:0] ch;
		logic       bank;
		fm_reg_t    d;
		first_rnd    = $urandom(32'hf50d);
		rst          = 1'b1;
		wr           = 1'b0;
		addr         = 2'b00;
		din          = '0;
		params_on    = 1'b1;
		param_checks = 0;
		ref_div      = 6;
		ref_preset_a = '0;
		ref_preset_b = '0;
		ref_lfo      = '0;
		for (i = 0; i < `FM_NUM_SLOTS; i++) begin
			sh_dt_mul[i] = '0;
			sh_tl[i]     = '0;
			sh_ks_ar[i]  = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// reset state
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("irq", irq, 1'b0);
		check_bit("flag_a", flag_a, 1'b0);
		check_bit("flag_b", flag_b, 1'b0);
		check_bit("lfo_en", lfo_en, 1'b0);
		measure_interval(n);
		check_count("clk_en interval", n, ref_div);
		wait_param_checks(`FM_NUM_SLOTS);

		// random operator writes, every 8th into a hole
		params_on = 1'b0;
		for (i = 0; i < 40; i++) begin
			grp  = 4'(3 + $urandom % 3);
			op   = 2'($urandom % 4);
			ch   = (i % 8 == 7) ? 2'd3 : 2'($urandom % 3);
			bank = 1'($urandom % 2);
			d    = fm_reg_t'($urandom);
			reg_write({grp, op, ch}, d, bank);
		end
		wait_busy_low();
		params_on = 1'b1;
		wait_param_checks(2 * `FM_NUM_SLOTS);

		// busy, 0x33 is a hole so memory stays put
		write_addr(8'h33, 1'b0);
		repeat (3) begin
			@(negedge clk);
			check_bit("busy", busy, 1'b0); // address write alone
		end
		write_data(8'h00, 1'b0);
		count_ticks_until(1, 0, 1000, n);
		check_count("busy ticks", n, `FM_BUSY_TICKS);
		write_data(8'h00, 1'b0);
		wait_ticks(10);
		check_bit("busy", busy, 1'b1);
		write_data(8'h00, 1'b0); // restart mid count
		count_ticks_until(1, 0, 1000, n);
		check_count("busy ticks after restart", n, `FM_BUSY_TICKS);

		// divider and LFO
		reg_write(`FM_REG_CLK_N3, 8'h00, 1'b0);
		settle(1);
		repeat (2) begin
			measure_interval(n);
			check_count("clk_en interval", n, ref_div);
		end
		reg_write(`FM_REG_CLK_N2, 8'h00, 1'b0);
		settle(1);
		repeat (2) begin
			measure_interval(n);
			check_count("clk_en interval", n, ref_div);
		end
		reg_write(`FM_REG_CLK_N6, 8'h00, 1'b0);
		settle(1);
		repeat (2) begin
			measure_interval(n);
			check_count("clk_en interval", n, ref_div);
		end
		reg_write(`FM_REG_LFO, fm_reg_t'($urandom) | 8'h08, 1'b0); // enable bit set
		settle(1);
		check_bit("lfo_en", lfo_en, ref_lfo[3]);
		check_count("lfo_freq", lfo_freq, ref_lfo[2:0]);

		// timer A, load and irq enable
		n = 1000 + $urandom % 21;
		reg_write(`FM_REG_CLKA1, fm_reg_t'(n >> 2), 1'b0);
		reg_write(`FM_REG_CLKA2, fm_reg_t'(n & 3), 1'b0);
		reg_write(`FM_REG_TIMER, 8'h05, 1'b0);
		count_ticks_until(2, 1, 4000, n);
		check_count("timer A period", n, 1024 - int'(ref_preset_a));
		check_bit("irq", irq, 1'b1);
		reg_write(`FM_REG_TIMER, 8'h10, 1'b0); // clear A, stop
		settle(2);
		check_bit("flag_a", flag_a, 1'b0);
		check_bit("irq", irq, 1'b0);
		reg_write(`FM_REG_TIMER, 8'h01, 1'b0); // run with irq disabled
		wait_ticks(2 * (1024 - int'(ref_preset_a)) + 4);
		check_bit("flag_a", flag_a, 1'b0);
		check_bit("irq", irq, 1'b0);
		reg_write(`FM_REG_TIMER, 8'h00, 1'b0);

		// timer B, prescaled by 16
		reg_write(`FM_REG_CLKB, fm_reg_t'(250 + $urandom % 5), 1'b0);
		reg_write(`FM_REG_TIMER, 8'h0A, 1'b0);
		count_ticks_until(2, 2, 8000, n);
		check_count("timer B period", n, (256 - int'(ref_preset_b)) * `FM_TMRB_PRESCALE);
		check_bit("irq", irq, 1'b1);
		check_bit("flag_a", flag_a, 1'b0);
		reg_write(`FM_REG_TIMER, 8'h20, 1'b0); // clear B, stop
		settle(2);
		check_bit("flag_b", flag_b, 1'b0);
		check_bit("irq", irq, 1'b0);

		if (u_fm_top.u_fm_assertions.fail_count != 0) begin
			$display("%0d assertion failures during the run",
				u_fm_top.u_fm_assertions.fail_count);
			stop_failed();
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- fm_timers.sv
`default_nettype none

`include "fm_defines.svh"

module fm_timers (
	input  logic             clk,
	input  logic             rst,
	input  logic             clk_en,
	input  fm_pkg::fm_tmra_t preset_a,
	input  fm_pkg::fm_tmrb_t preset_b,
	input  logic             load_a,   // run timer A
	input  logic             load_b,   // run timer B
	input  logic             irq_en_a,
	input  logic             irq_en_b,
	input  logic             clr_a,    // flag clear strobes
	input  logic             clr_b,
	output logic             flag_a,
	output logic             flag_b,
	output logic             irq
);
	import fm_pkg::*;

	localparam int PRE_W = $clog2(`FM_TMRB_PRESCALE);

	fm_tmra_t         cnt_a;
	fm_tmrb_t         cnt_b;
	logic [PRE_W-1:0] pre_b;    // timer B prescaler
	logic             load_a_q; // for rise detection
	logic             load_b_q;
	logic             tick_b;

	assign tick_b = clk_en && (pre_b == PRE_W'(`FM_TMRB_PRESCALE - 1));

	// timer A, one step per synthesis tick
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_a    <= '0;
			load_a_q <= 1'b0;
			flag_a   <= 1'b0;
		end else begin
			load_a_q <= load_a;
			if (clr_a)
				flag_a <= 1'b0;
			if (load_a && !load_a_q) begin
				cnt_a <= preset_a; // start of first period
			end else if (load_a && clk_en) begin
				if (cnt_a == '1) begin
					cnt_a <= preset_a; // overflow, reload
					if (irq_en_a)
						flag_a <= 1'b1; // set wins over clear
				end else begin
					cnt_a <= cnt_a + 10'd1;
				end
			end
		end
	end

	// timer B, same scheme behind the prescaler
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_b    <= '0;
			pre_b    <= '0;
			load_b_q <= 1'b0;
			flag_b   <= 1'b0;
		end else begin
			load_b_q <= load_b;
			if (clr_b)
				flag_b <= 1'b0;
			if (load_b && !load_b_q) begin
				cnt_b <= preset_b;
				pre_b <= '0; // full prescale interval first
			end else if (load_b && clk_en) begin
				pre_b <= pre_b + 1'b1; // wraps at prescale
				if (tick_b) begin
					if (cnt_b == '1) begin
						cnt_b <= preset_b;
						if (irq_en_b)
							flag_b <= 1'b1;
					end else begin
						cnt_b <= cnt_b + 8'd1;
					end
				end
			end
		end
	end

	assign irq = flag_a | flag_b;

endmodule

`default_nettype wire

//--- fm_top.sv
`default_nettype none

module fm_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr,
	input  logic [1:0]       addr,
	input  fm_pkg::fm_reg_t  din,
	output logic             busy,
	output logic             clk_en,
	output logic             irq,
	output logic             flag_a,
	output logic             flag_b,
	output logic             lfo_en,
	output logic [2:0]       lfo_freq,
	output fm_pkg::fm_slot_t slot,
	output logic [2:0]       dt1,
	output logic [3:0]       mul,
	output logic [6:0]       tl,
	output logic [1:0]       ks,
	output logic [4:0]       ar
);
	import fm_pkg::*;

	logic       div_wr;
	fm_div_t    div_sel;
	fm_tmra_t   preset_a;
	fm_tmrb_t   preset_b;
	logic       load_a;
	logic       load_b;
	logic       irq_en_a;
	logic       irq_en_b;
	logic       clr_a;
	logic       clr_b;
	logic       op_wr;
	fm_slot_t   op_slot;
	logic [1:0] op_field;
	fm_reg_t    op_data;

	fm_mmr_ctrl u_mmr_ctrl (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.din      (din),
		.clk_en   (clk_en),
		.busy     (busy),
		.lfo_en   (lfo_en),
		.lfo_freq (lfo_freq),
		.div_wr   (div_wr),
		.div_sel  (div_sel),
		.preset_a (preset_a),
		.preset_b (preset_b),
		.load_a   (load_a),
		.load_b   (load_b),
		.irq_en_a (irq_en_a),
		.irq_en_b (irq_en_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b),
		.op_wr    (op_wr),
		.op_slot  (op_slot),
		.op_field (op_field),
		.op_data  (op_data)
	);

	// synthesis tick for every block
	fm_clk_div u_clk_div (
		.clk     (clk),
		.rst     (rst),
		.div_wr  (div_wr),
		.div_sel (div_sel),
		.clk_en  (clk_en)
	);

	fm_timers u_timers (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.preset_a (preset_a),
		.preset_b (preset_b),
		.load_a   (load_a),
		.load_b   (load_b),
		.irq_en_a (irq_en_a),
		.irq_en_b (irq_en_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.irq      (irq)
	);

	fm_op_regs u_op_regs (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.op_wr    (op_wr),
		.op_slot  (op_slot),
		.op_field (op_field),
		.op_data  (op_data),
		.slot     (slot),
		.dt1      (dt1),
		.mul      (mul),
		.tl       (tl),
		.ks       (ks),
		.ar       (ar)
	);

endmodule

`default_nettype wire
